/* src/dsi3_pkg.sv */
// Shared DSI3 receive types and timing, all cycle counts assume a 4 MHz clock (4 cycles per us)
package dsi3_pkg;

	// Comparator encoding, MSB is the higher current threshold
	typedef enum logic [1:0] {
		C0 = 2'b00,
		C1 = 2'b01,
		CX = 2'b10,
		C2 = 2'b11
	} dsi3_chip_e;

	// First chip of the triple sits in bits 5:4
	typedef logic [5:0] dsi3_symbol_t;
	typedef logic [3:0] nibble_t;
	typedef logic [31:0] rx_data_t;
	typedef logic [8:0] symbol_count_t;
	typedef logic [1:0] sample_cfg_t;
	// Wide enough for the longest chip of 24 cycles
	typedef logic [4:0] chip_timer_t;

	localparam int CYCLES_PER_US = 4;
	localparam int CHIP_CYCLES_BASE = 3 * CYCLES_PER_US;
	localparam int FILTER_LEN = 4;
	localparam int FILTER_LEN_SHORT = 2;
	localparam int DATA_NIBBLES = 8;

	// Base-3 digit of one chip
	function automatic logic [1:0] chip_digit(input dsi3_chip_e chip);
		case (chip)
			C1: chip_digit = 2'd1;
			C2: chip_digit = 2'd2;
			default: chip_digit = 2'd0;
		endcase
	endfunction

	// Valid triples start with C1 or C2, minus C1C1C1 (13) and C2C2C2 (26)
	function automatic nibble_t decode_symbol(
		input dsi3_symbol_t sym,
		output logic invalid_chip,
		output logic invalid_symbol
	);
		logic [4:0] value;
		logic [1:0] first;
		first = chip_digit(dsi3_chip_e'(sym[5:4]));
		value = 5'd9 * first + 5'd3 * chip_digit(dsi3_chip_e'(sym[3:2]))
			+ chip_digit(dsi3_chip_e'(sym[1:0]));
		invalid_chip = (sym[5:4] == CX) || (sym[3:2] == CX) || (sym[1:0] == CX);
		// C0C0C0 is the end marker, not an error
		invalid_symbol = !invalid_chip
			&& (((first == 2'd0) && (value != 5'd0)) || (value == 5'd13) || (value == 5'd26));
		if (invalid_chip || invalid_symbol || (first == 2'd0)) begin
			decode_symbol = '0;
		end else if (value < 5'd13) begin
			decode_symbol = nibble_t'(value - 5'd9);
		end else begin
			decode_symbol = nibble_t'(value - 5'd10);
		end
	endfunction

endpackage

/* src/dsi3_filter.sv */
// i_rx is treated as asynchronous, a level shorter than the filter length never reaches the chip output
`timescale 1ns/1ps
module dsi3_filter (
	input  logic                 clk,
	input  logic                 i_rst,
	input  logic [1:0]           i_rx,
	input  logic                 i_shorter_filter,
	output dsi3_pkg::dsi3_chip_e o_chip_filtered,
	output logic [1:0]           o_rx_filtered,
	output logic [1:0]           o_rx_test
);

	logic [1:0] rx_meta;
	logic [1:0] rx_sync;
	logic [1:0] rx_hold;
	logic [2:0] stable_cnt;
	logic [2:0] stable_now;
	logic [2:0] filter_len;

	// Cycles the synchronized value has held, including this one
	always_comb begin
		if (i_shorter_filter) begin
			filter_len = 3'(dsi3_pkg::FILTER_LEN_SHORT);
		end else begin
			filter_len = 3'(dsi3_pkg::FILTER_LEN);
		end
		if (rx_sync != rx_hold) begin
			stable_now = 3'd1;
		end else if (stable_cnt >= filter_len) begin
			// Saturate so a long stable level cannot wrap
			stable_now = filter_len;
		end else begin
			stable_now = stable_cnt + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			rx_meta <= '0;
			rx_sync <= '0;
			rx_hold <= '0;
			stable_cnt <= '0;
			o_chip_filtered <= dsi3_pkg::C0;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
			rx_hold <= rx_sync;
			stable_cnt <= stable_now;
			if (stable_now >= filter_len) begin
				o_chip_filtered <= dsi3_pkg::dsi3_chip_e'(rx_sync);
			end
		end
	end

	assign o_rx_test = rx_sync;

	// Thermometer code, CX shows as no current
	assign o_rx_filtered[0] = (o_chip_filtered == dsi3_pkg::C1)
		|| (o_chip_filtered == dsi3_pkg::C2);
	assign o_rx_filtered[1] = (o_chip_filtered == dsi3_pkg::C2);

endmodule

/* src/dsi3_receive_sampling.sv */
// Chip time follows i_sample_cfg, which must stay constant while a response is being received
`timescale 1ns/1ps
module dsi3_receive_sampling (
	input  logic                  clk,
	input  logic                  i_rst,
	input  logic                  i_enable,
	input  dsi3_pkg::sample_cfg_t i_sample_cfg,
	input  logic                  i_stop_receiving,
	input  dsi3_pkg::dsi3_chip_e  i_chip,
	output dsi3_pkg::dsi3_chip_e  o_chip,
	output logic                  o_chip_ready,
	output logic                  o_receiving,
	output logic                  o_rec_start_tick
);

	typedef enum logic [1:0] {
		IDLE,
		FIRST_HALF,
		RUN
	} state_e;

	state_e state;
	dsi3_pkg::chip_timer_t timer;
	dsi3_pkg::chip_timer_t period;
	dsi3_pkg::chip_timer_t half_period;
	logic sample_now;

	// 3 us plus 1 us per cfg step
	always_comb begin
		period = dsi3_pkg::chip_timer_t'(dsi3_pkg::CHIP_CYCLES_BASE)
			+ dsi3_pkg::chip_timer_t'(i_sample_cfg)
			* dsi3_pkg::chip_timer_t'(dsi3_pkg::CYCLES_PER_US);
		half_period = period >> 1;
	end

	assign o_rec_start_tick = (state == IDLE) && i_enable && (i_chip != dsi3_pkg::C0);
	assign o_receiving = (state != IDLE);
	assign sample_now = (state != IDLE) && (timer == '0);

	always_ff @(posedge clk) begin
		if (i_rst || !i_enable) begin
			state <= IDLE;
			timer <= '0;
			o_chip_ready <= 1'b0;
		end else begin
			o_chip_ready <= 1'b0;
			case (state)
				IDLE: begin
					if (o_rec_start_tick) begin
						// First strobe lands half a chip after start
						timer <= half_period - 5'd2;
						state <= FIRST_HALF;
					end
				end
				FIRST_HALF, RUN: begin
					if (i_stop_receiving) begin
						state <= IDLE;
					end else if (timer == '0) begin
						o_chip_ready <= 1'b1;
						timer <= period - 5'd1;
						state <= RUN;
					end else begin
						timer <= timer - 5'd1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Sampled level, valid with o_chip_ready
	always_ff @(posedge clk) begin
		if (sample_now) begin
			o_chip <= i_chip;
		end
	end

endmodule

/* src/dsi3_symbol_builder.sv */
// Symbol outputs are valid only in the cycle of o_symbol_ready
`timescale 1ns/1ps
module dsi3_symbol_builder (
	input  logic                 clk,
	input  logic                 i_rst,
	input  logic                 i_enable,
	input  logic                 i_stop_receiving,
	input  dsi3_pkg::dsi3_chip_e i_chip,
	input  logic                 i_chip_ready,
	output logic                 o_symbol_ready,
	output dsi3_pkg::nibble_t    o_nibble,
	output logic                 o_symbol_error,
	output logic                 o_end_marker
);

	dsi3_pkg::dsi3_symbol_t sym_q;
	logic [1:0] phase;
	logic invalid_chip;
	logic invalid_symbol;

	// Phase counts chips within the current triple
	always_ff @(posedge clk) begin
		if (i_rst || !i_enable || i_stop_receiving) begin
			phase <= '0;
			o_symbol_ready <= 1'b0;
		end else begin
			o_symbol_ready <= i_chip_ready && (phase == 2'd2);
			if (i_chip_ready) begin
				if (phase == 2'd2) begin
					phase <= '0;
				end else begin
					phase <= phase + 2'd1;
				end
			end
		end
	end

	// Oldest chip ends up in the top bits
	always_ff @(posedge clk) begin
		if (i_chip_ready) begin
			sym_q <= {sym_q[3:0], i_chip};
		end
	end

	always_comb begin
		o_nibble = dsi3_pkg::decode_symbol(sym_q, invalid_chip, invalid_symbol);
		o_symbol_error = invalid_chip || invalid_symbol;
		o_end_marker = (sym_q == {3{dsi3_pkg::C0}});
	end

endmodule

/* src/dsi3_receive_data_collect.sv */
// Keeps only the last 8 nibbles, a response ends on end marker, timeout or 511 symbols
`timescale 1ns/1ps
module dsi3_receive_data_collect (
	input  logic                    clk,
	input  logic                    i_rst,
	input  logic                    i_enable_receiver,
	input  logic                    i_rec_start_tick,
	input  logic                    i_symbol_ready,
	input  dsi3_pkg::nibble_t       i_nibble,
	input  logic                    i_symbol_error,
	input  logic                    i_end_marker,
	input  logic                    i_receive_time_out,
	output logic                    o_stop_receiving,
	output logic                    o_received_data,
	output logic                    o_response_finished,
	output logic                    o_symbol_error_set,
	output dsi3_pkg::rx_data_t      o_data,
	output dsi3_pkg::symbol_count_t o_symbol_count,
	output logic                    o_symbol_count_overflow
);

	logic active;
	logic symbol_valid;
	logic count_full;
	logic end_event;
	dsi3_pkg::symbol_count_t count_next;

	always_comb begin
		symbol_valid = active && i_symbol_ready && !i_symbol_error && !i_end_marker;
		count_next = o_symbol_count;
		if (symbol_valid) begin
			count_next = o_symbol_count + 1'b1;
		end
		count_full = symbol_valid && (count_next == '1);
		// Only a started response can be ended
		end_event = active
			&& ((i_symbol_ready && i_end_marker) || i_receive_time_out || count_full);
	end

	always_ff @(posedge clk) begin
		if (i_rst || !i_enable_receiver) begin
			active <= 1'b0;
			o_response_finished <= 1'b0;
			o_received_data <= 1'b0;
			o_symbol_error_set <= 1'b0;
			o_symbol_count <= '0;
			o_symbol_count_overflow <= 1'b0;
			o_data <= '0;
		end else begin
			o_response_finished <= end_event;
			o_received_data <= end_event && (count_next != '0);
			o_symbol_error_set <= active && i_symbol_ready && i_symbol_error;
			if (i_rec_start_tick) begin
				active <= 1'b1;
				o_symbol_count <= '0;
				o_symbol_count_overflow <= 1'b0;
				o_data <= '0;
			end else begin
				if (end_event) begin
					active <= 1'b0;
				end
				if (symbol_valid) begin
					o_symbol_count <= count_next;
					// Newest nibble enters at the bottom
					o_data <= {o_data[(dsi3_pkg::DATA_NIBBLES - 1) * 4 - 1:0], i_nibble};
				end
				if (count_full) begin
					o_symbol_count_overflow <= 1'b1;
				end
			end
		end
	end

	// Stop goes out together with the finish pulse
	assign o_stop_receiving = o_response_finished;

endmodule

/* src/dsi3_receive.sv */
// DSI3 master receive path, assumes clk runs at 4 cycles per us and i_rx is asynchronous
`timescale 1ns/1ps
module dsi3_receive (
	input  logic                    clk,
	input  logic                    i_rst,
	input  logic                    i_enable_receiver,
	// MSB is the higher current comparator
	input  logic [1:0]              i_rx,
	// Chip time 3 us + cfg
	input  dsi3_pkg::sample_cfg_t   i_sample_cfg,
	input  logic                    i_receive_time_out,
	output logic                    o_rec_pending,
	output logic                    o_received_data,
	output logic                    o_symbol_error_set,
	output logic                    o_response_finished,
	output dsi3_pkg::rx_data_t      o_data,
	output logic [1:0]              o_rx_test,
	output logic [1:0]              o_rx_filtered,
	output dsi3_pkg::symbol_count_t o_symbol_count,
	output logic                    o_symbol_count_overflow,
	output logic                    o_receiving_started_tick
);

	dsi3_pkg::dsi3_chip_e chip_filtered;
	dsi3_pkg::dsi3_chip_e chip_sampled;
	logic chip_ready;
	logic rec_start_tick;
	logic stop_receiving;
	logic symbol_ready;
	dsi3_pkg::nibble_t nibble;
	logic symbol_error;
	logic end_marker;

	dsi3_filter dsi3_filter_inst (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_rx             (i_rx),
		.i_shorter_filter (i_sample_cfg == '0),
		.o_chip_filtered  (chip_filtered),
		.o_rx_filtered    (o_rx_filtered),
		.o_rx_test        (o_rx_test)
	);

	dsi3_receive_sampling dsi3_receive_sampling_inst (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_enable         (i_enable_receiver),
		.i_sample_cfg     (i_sample_cfg),
		.i_stop_receiving (stop_receiving),
		.i_chip           (chip_filtered),
		.o_chip           (chip_sampled),
		.o_chip_ready     (chip_ready),
		.o_receiving      (o_rec_pending),
		.o_rec_start_tick (rec_start_tick)
	);

	assign o_receiving_started_tick = rec_start_tick;

	dsi3_symbol_builder dsi3_symbol_builder_inst (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_enable         (i_enable_receiver),
		.i_stop_receiving (stop_receiving),
		.i_chip           (chip_sampled),
		.i_chip_ready     (chip_ready),
		.o_symbol_ready   (symbol_ready),
		.o_nibble         (nibble),
		.o_symbol_error   (symbol_error),
		.o_end_marker     (end_marker)
	);

	dsi3_receive_data_collect dsi3_receive_data_collect_inst (
		.clk                     (clk),
		.i_rst                   (i_rst),
		.i_enable_receiver       (i_enable_receiver),
		.i_rec_start_tick        (rec_start_tick),
		.i_symbol_ready          (symbol_ready),
		.i_nibble                (nibble),
		.i_symbol_error          (symbol_error),
		.i_end_marker            (end_marker),
		.i_receive_time_out      (i_receive_time_out),
		.o_stop_receiving        (stop_receiving),
		.o_received_data         (o_received_data),
		.o_response_finished     (o_response_finished),
		.o_symbol_error_set      (o_symbol_error_set),
		.o_data                  (o_data),
		.o_symbol_count          (o_symbol_count),
		.o_symbol_count_overflow (o_symbol_count_overflow)
	);

endmodule

/* tests/tb_dsi3_receive.sv */
// Directed tests assume 4 cycles per us and derive expected values from the DSI3 chip and symbol rules
`timescale 1ns/1ps
module tb_dsi3_receive;

	localparam int CLK_PERIOD = 20;
	// Chips sent over all tests with the longest chip of 24 cycles
	localparam int TOTAL_CHIPS = 1700;
	localparam int WATCHDOG_CYCLES = 2 * TOTAL_CHIPS * 24 + 2000;
	localparam logic [1:0] RX_C0 = 2'b00;
	localparam logic [1:0] RX_C1 = 2'b01;
	localparam logic [1:0] RX_C2 = 2'b11;
	localparam logic [1:0] RX_CX = 2'b10;

	logic clk;
	logic i_rst;
	logic i_enable_receiver;
	logic [1:0] i_rx;
	dsi3_pkg::sample_cfg_t i_sample_cfg;
	logic i_receive_time_out;
	logic o_rec_pending;
	logic o_received_data;
	logic o_symbol_error_set;
	logic o_response_finished;
	logic [31:0] o_data;
	logic [1:0] o_rx_test;
	logic [1:0] o_rx_filtered;
	logic [8:0] o_symbol_count;
	logic o_symbol_count_overflow;
	logic o_receiving_started_tick;

	integer seed;
	int error_count;
	int check_count;
	int finish_cnt;
	int data_cnt;
	int sym_err_cnt;
	int start_cnt;
	logic pending_seen;
	logic [31:0] cap_data;
	logic [8:0] cap_count;
	logic cap_overflow;
	logic [31:0] exp_data;
	logic [3:0] tx_nibbles[$];

	dsi3_receive dsi3_receive_inst (
		.clk                      (clk),
		.i_rst                    (i_rst),
		.i_enable_receiver        (i_enable_receiver),
		.i_rx                     (i_rx),
		.i_sample_cfg             (i_sample_cfg),
		.i_receive_time_out       (i_receive_time_out),
		.o_rec_pending            (o_rec_pending),
		.o_received_data          (o_received_data),
		.o_symbol_error_set       (o_symbol_error_set),
		.o_response_finished      (o_response_finished),
		.o_data                   (o_data),
		.o_rx_test                (o_rx_test),
		.o_rx_filtered            (o_rx_filtered),
		.o_symbol_count           (o_symbol_count),
		.o_symbol_count_overflow  (o_symbol_count_overflow),
		.o_receiving_started_tick (o_receiving_started_tick)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Pulse counters and values captured with the finish pulse
	initial begin
		forever begin
			@(negedge clk);
			if (o_response_finished) begin
				finish_cnt++;
				cap_data = o_data;
				cap_count = o_symbol_count;
				cap_overflow = o_symbol_count_overflow;
			end
			if (o_received_data) begin
				data_cnt++;
			end
			if (o_symbol_error_set) begin
				sym_err_cnt++;
			end
			if (o_receiving_started_tick) begin
				start_cnt++;
			end
			if (o_rec_pending) begin
				pending_seen = 1'b1;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	function automatic int chip_cycles(input logic [1:0] cfg);
		return dsi3_pkg::CHIP_CYCLES_BASE + int'(cfg) * dsi3_pkg::CYCLES_PER_US;
	endfunction

	function automatic logic [1:0] digit_to_rx(input int digit);
		case (digit)
			1: digit_to_rx = RX_C1;
			2: digit_to_rx = RX_C2;
			default: digit_to_rx = RX_C0;
		endcase
	endfunction

	// Valid triples in ascending base-3 order without C0xx, C1C1C1 and C2C2C2
	function automatic logic [5:0] encode_nibble(input logic [3:0] nib);
		int idx;
		int value;
		int v;
		idx = 0;
		value = 0;
		for (v = 9; v < 27; v++) begin
			if (v != 13 && v != 26) begin
				if (idx == int'(nib)) begin
					value = v;
				end
				idx++;
			end
		end
		return {digit_to_rx(value / 9), digit_to_rx((value / 3) % 3), digit_to_rx(value % 3)};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		check_count++;
		assert (cond) else begin
			$display("Check failed: %s", what);
			error_count++;
		end
	endtask

	task automatic clear_monitor();
		@(posedge clk);
		finish_cnt = 0;
		data_cnt = 0;
		sym_err_cnt = 0;
		start_cnt = 0;
		pending_seen = 1'b0;
	endtask

	task automatic send_chip(input logic [1:0] rx);
		@(negedge clk);
		i_rx = rx;
		repeat (chip_cycles(i_sample_cfg) - 1) @(negedge clk);
	endtask

	task automatic send_triple(input logic [5:0] chips);
		send_chip(chips[5:4]);
		send_chip(chips[3:2]);
		send_chip(chips[1:0]);
	endtask

	// Sends the queued nibbles with the newest expected in the low bits
	task automatic send_response(input bit with_end);
		exp_data = '0;
		foreach (tx_nibbles[i]) begin
			send_triple(encode_nibble(tx_nibbles[i]));
			exp_data = {exp_data[27:0], tx_nibbles[i]};
		end
		if (with_end) begin
			send_triple({RX_C0, RX_C0, RX_C0});
		end
	endtask

	task automatic pulse_timeout();
		@(negedge clk);
		i_receive_time_out = 1'b1;
		@(negedge clk);
		i_receive_time_out = 1'b0;
	endtask

	task automatic wait_finish(input int limit);
		int n;
		n = 0;
		while (finish_cnt == 0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		check_true(finish_cnt != 0, "response did not finish in time");
		// Room for any stray second pulse
		repeat (2 * chip_cycles(i_sample_cfg)) @(negedge clk);
	endtask

	task automatic test_filter();
		int cycles;
		int c;
		clear_monitor();
		@(negedge clk);
		i_sample_cfg = 2'd1;
		i_rx = RX_C2;
		@(negedge clk);
		i_rx = RX_C0;
		@(negedge clk);
		check_value("o_rx_test", o_rx_test, RX_C2);
		repeat (8) begin
			@(negedge clk);
			check_value("o_rx_test", o_rx_test, RX_C0);
			check_value("o_rx_filtered", o_rx_filtered, 2'b00);
		end
		check_value("o_receiving_started_tick pulses", start_cnt, 0);
		for (c = 0; c < 2; c++) begin
			i_sample_cfg = 2'(c);
			i_rx = (c == 0) ? RX_C1 : RX_C2;
			cycles = 0;
			while (!o_receiving_started_tick && cycles < 20) begin
				@(negedge clk);
				cycles++;
			end
			check_value("o_receiving_started_tick delay", cycles,
				(c == 0) ? 2 + dsi3_pkg::FILTER_LEN_SHORT : 2 + dsi3_pkg::FILTER_LEN);
			check_value("o_rx_filtered", o_rx_filtered, (c == 0) ? 2'b01 : 2'b11);
			i_rx = RX_C0;
			repeat (10) @(negedge clk);
			i_enable_receiver = 1'b0;
			@(negedge clk);
			i_enable_receiver = 1'b1;
		end
	endtask

	task automatic test_random_response(input logic [1:0] cfg);
		@(negedge clk);
		i_sample_cfg = cfg;
		tx_nibbles.delete();
		repeat (dsi3_pkg::DATA_NIBBLES) tx_nibbles.push_back(4'($random(seed)));
		clear_monitor();
		send_response(1'b1);
		wait_finish(4 * chip_cycles(cfg));
		check_value("o_response_finished pulses", finish_cnt, 1);
		check_value("o_received_data pulses", data_cnt, 1);
		check_value("o_data", cap_data, exp_data);
		check_value("o_symbol_count", cap_count, 8);
		check_value("o_symbol_count_overflow", cap_overflow, 0);
		check_value("o_rec_pending", o_rec_pending, 0);
	endtask

	task automatic test_symbol_errors();
		logic [3:0] a;
		logic [3:0] b;
		logic [3:0] c;
		@(negedge clk);
		i_sample_cfg = 2'd1;
		a = 4'($random(seed));
		b = 4'($random(seed));
		c = 4'($random(seed));
		clear_monitor();
		send_triple(encode_nibble(a));
		send_triple({RX_C1, RX_CX, RX_C2});
		send_triple(encode_nibble(b));
		send_triple({RX_C1, RX_C1, RX_C1});
		send_triple({RX_C0, RX_C2, RX_C1});
		send_triple(encode_nibble(c));
		send_triple({RX_C0, RX_C0, RX_C0});
		wait_finish(4 * chip_cycles(i_sample_cfg));
		check_value("o_symbol_error_set pulses", sym_err_cnt, 3);
		check_value("o_symbol_count", cap_count, 3);
		check_value("o_data", cap_data, {20'h0, a, b, c});
		check_value("o_received_data pulses", data_cnt, 1);
	endtask

	task automatic test_timeout();
		@(negedge clk);
		i_sample_cfg = 2'd2;
		tx_nibbles.delete();
		repeat (3) tx_nibbles.push_back(4'($random(seed)));
		clear_monitor();
		send_response(1'b0);
		@(negedge clk);
		i_rx = RX_C0;
		repeat (8) @(negedge clk);
		check_value("o_rec_pending", o_rec_pending, 1);
		pulse_timeout();
		wait_finish(8);
		check_value("o_received_data pulses", data_cnt, 1);
		check_value("o_symbol_count", cap_count, 3);
		check_value("o_data", cap_data, exp_data);
		check_value("o_rec_pending", o_rec_pending, 0);
		// Started but no complete symbol yet
		clear_monitor();
		send_chip(RX_C2);
		@(negedge clk);
		i_rx = RX_C0;
		repeat (8) @(negedge clk);
		pulse_timeout();
		wait_finish(8);
		check_value("o_received_data pulses", data_cnt, 0);
		check_value("o_rec_pending", o_rec_pending, 0);
		clear_monitor();
		pulse_timeout();
		repeat (8) @(negedge clk);
		check_value("o_response_finished pulses", finish_cnt, 0);
	endtask

	task automatic test_overflow();
		@(negedge clk);
		i_sample_cfg = 2'd0;
		tx_nibbles.delete();
		repeat (510) tx_nibbles.push_back(4'($random(seed)));
		// C1C0C0 leaves the line at C0 after the last symbol
		tx_nibbles.push_back(4'h0);
		clear_monitor();
		send_response(1'b0);
		wait_finish(4 * chip_cycles(i_sample_cfg));
		check_value("o_symbol_count_overflow", cap_overflow, 1);
		check_value("o_symbol_count", cap_count, 511);
		check_value("o_data", cap_data, exp_data);
		check_value("o_response_finished pulses", finish_cnt, 1);
		check_value("o_received_data pulses", data_cnt, 1);
	endtask

	task automatic test_disable();
		@(negedge clk);
		i_enable_receiver = 1'b0;
		i_sample_cfg = 2'd1;
		tx_nibbles.delete();
		repeat (4) tx_nibbles.push_back(4'($random(seed)));
		clear_monitor();
		send_response(1'b1);
		repeat (2 * chip_cycles(i_sample_cfg)) @(negedge clk);
		check_value("o_response_finished pulses", finish_cnt, 0);
		check_value("o_received_data pulses", data_cnt, 0);
		check_value("o_symbol_error_set pulses", sym_err_cnt, 0);
		check_value("o_receiving_started_tick pulses", start_cnt, 0);
		check_true(!pending_seen, "o_rec_pending rose while the receiver was disabled");
		check_value("o_symbol_count", o_symbol_count, 0);
		check_value("o_data", o_data, 0);
		i_enable_receiver = 1'b1;
	endtask

	initial begin
		seed = 32'h22f4;
		error_count = 0;
		check_count = 0;
		i_rst = 1'b1;
		i_enable_receiver = 1'b0;
		i_rx = RX_C0;
		i_sample_cfg = 2'd0;
		i_receive_time_out = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		i_rst = 1'b0;
		i_enable_receiver = 1'b1;
		repeat (4) @(negedge clk);
		check_value("o_rec_pending", o_rec_pending, 0);
		test_filter();
		for (int cfg = 0; cfg < 4; cfg++) begin
			test_random_response(2'(cfg));
		end
		test_symbol_errors();
		test_timeout();
		test_overflow();
		test_disable();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* sources.f */
src/dsi3_pkg.sv
src/dsi3_filter.sv
src/dsi3_receive_sampling.sv
src/dsi3_symbol_builder.sv
src/dsi3_receive_data_collect.sv
src/dsi3_receive.sv
tests/tb_dsi3_receive.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the result from the log
cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dsi3_receive -Mdir "$build_dir" -o tb_dsi3_receive \
	-f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/tb_dsi3_receive" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "sim passed" "$log_file"; then
	exit 0
fi
echo "Pass message not found in $log_file"
exit 1
